// File: source/lstm_pkg.sv
package lstm_pkg;

	////////////////////////////////////////////////////////////////////////////
	// fixed-point format
	////////////////////////////////////////////////////////////////////////////

	// signed Q8.24 words
	localparam int FX_W    = 32;
	localparam int FX_FRAC = 24;

	// width of a full product before scaling back
	localparam int FX_PROD_W = 2 * FX_W;

	// 1.0 and 0.5 in Q8.24
	localparam logic signed [FX_W-1:0] FX_ONE  = FX_W'(1) <<< FX_FRAC;
	localparam logic signed [FX_W-1:0] FX_HALF = FX_ONE >>> 1;

	////////////////////////////////////////////////////////////////////////////
	// activation selection
	////////////////////////////////////////////////////////////////////////////

	// sigmoid for the i, f, o gates, tanh for the a gate and the state
	typedef enum logic
	{
		ACT_SIGMOID = 1'b0,
		ACT_TANH    = 1'b1
	} act_kind_e;

	////////////////////////////////////////////////////////////////////////////
	// arithmetic
	////////////////////////////////////////////////////////////////////////////

	// Q8.24 multiply, full 64-bit product then arithmetic shift by the
	// fraction width. Taking the slice of the signed product floors toward
	// minus infinity; bits above the 32-bit window are dropped, so the
	// result wraps like the adders do
	function automatic logic signed [FX_W-1:0] fx_mul
	(
		input logic signed [FX_W-1:0] a,
		input logic signed [FX_W-1:0] b
	);
		logic signed [FX_PROD_W-1:0] p;
		p = a * b;
		return p[FX_FRAC +: FX_W];
	endfunction

endpackage

// File: source/pwl_act.sv
`timescale 1ns/1ps

module pwl_act
	import lstm_pkg::*;
#(
	parameter act_kind_e ACT = ACT_SIGMOID
)
(
	input  logic signed [FX_W-1:0] i_x,
	output logic signed [FX_W-1:0] o_y
);

	generate
		if (ACT == ACT_SIGMOID)
		begin : g_sigmoid
			// hard sigmoid, x/4 + 1/2
			logic signed [FX_W-1:0] lin;

			// x/4 stays within range, so the offset cannot wrap
			assign lin = (i_x >>> 2) + FX_HALF;

			// clamp to [0, 1]
			always_comb
			begin
				if (lin < 0)
					o_y = '0;
				else if (lin > FX_ONE)
					o_y = FX_ONE;
				else
					o_y = lin;
			end
		end
		else
		begin : g_tanh
			// hard tanh, identity clamped to [-1, 1]
			always_comb
			begin
				if (i_x > FX_ONE)
					o_y = FX_ONE;
				else if (i_x < -FX_ONE)
					o_y = -FX_ONE;
				else
					o_y = i_x;
			end
		end
	endgenerate

endmodule

// File: source/gate_neuron.sv
`timescale 1ns/1ps

module gate_neuron
	import lstm_pkg::*;
#(
	parameter int        NUM_IN = 5,
	parameter act_kind_e ACT    = ACT_SIGMOID
)
(
	input  logic                     clk,
	input  logic                     rst,

	// parallel weight load
	input  logic                     i_wr,

	// neuron inputs, word 0 is h_prev
	input  logic [NUM_IN*FX_W-1:0]   i_k,

	// new weights and bias
	input  logic [NUM_IN*FX_W-1:0]   i_w,
	input  logic signed [FX_W-1:0]   i_b,

	// stored weights and bias for readback
	output logic [NUM_IN*FX_W-1:0]   o_w,
	output logic signed [FX_W-1:0]   o_b,

	// activation
	output logic signed [FX_W-1:0]   o_a
);

	////////////////////////////////////////////////////////////////////////////
	// weight and bias registers
	////////////////////////////////////////////////////////////////////////////

	logic [NUM_IN*FX_W-1:0] w_reg;
	logic signed [FX_W-1:0] b_reg;

	// all words copied at once while i_wr is high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			w_reg <= '0;
			b_reg <= '0;
		end
		else if (i_wr)
		begin
			w_reg <= i_w;
			b_reg <= i_b;
		end
	end

	assign o_w = w_reg;
	assign o_b = b_reg;

	////////////////////////////////////////////////////////////////////////////
	// multiply-accumulate
	////////////////////////////////////////////////////////////////////////////

	logic signed [FX_W-1:0] prod [NUM_IN];
	logic signed [FX_W-1:0] acc;

	// one multiplier per input word
	genvar k;
	generate
		for (k = 0; k < NUM_IN; k++)
		begin : g_mul
			assign prod[k] = fx_mul(w_reg[k*FX_W +: FX_W], i_k[k*FX_W +: FX_W]);
		end
	endgenerate

	// bias plus products, wraps on overflow
	always_comb
	begin
		acc = b_reg;
		for (int n = 0; n < NUM_IN; n++)
		begin
			acc = acc + prod[n];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// activation
	////////////////////////////////////////////////////////////////////////////

	pwl_act #(
		.ACT (ACT)
	) u_act (
		.i_x (acc),
		.o_y (o_a)
	);

endmodule

// File: source/lstm_cell.sv
`timescale 1ns/1ps

module lstm_cell
	import lstm_pkg::*;
#(
	parameter int NUM_X = 4
)
(
	input  logic                            clk,
	input  logic                            rst,

	// control levels and step strobe
	input  logic                            i_wr,
	input  logic                            i_step,
	input  logic                            i_cont,

	// external inputs
	input  logic [NUM_X*FX_W-1:0]           i_x,

	// gate weights, word 0 for h_prev
	input  logic [(NUM_X+1)*FX_W-1:0]       i_w_a,
	input  logic [(NUM_X+1)*FX_W-1:0]       i_w_i,
	input  logic [(NUM_X+1)*FX_W-1:0]       i_w_f,
	input  logic [(NUM_X+1)*FX_W-1:0]       i_w_o,

	// gate biases
	input  logic signed [FX_W-1:0]          i_b_a,
	input  logic signed [FX_W-1:0]          i_b_i,
	input  logic signed [FX_W-1:0]          i_b_f,
	input  logic signed [FX_W-1:0]          i_b_o,

	// readback for the training engine
	output logic [(NUM_X+1)*FX_W-1:0]       o_w_a,
	output logic [(NUM_X+1)*FX_W-1:0]       o_w_i,
	output logic [(NUM_X+1)*FX_W-1:0]       o_w_f,
	output logic [(NUM_X+1)*FX_W-1:0]       o_w_o,
	output logic signed [FX_W-1:0]          o_b_a,
	output logic signed [FX_W-1:0]          o_b_i,
	output logic signed [FX_W-1:0]          o_b_f,
	output logic signed [FX_W-1:0]          o_b_o,

	// gate activations
	output logic signed [FX_W-1:0]          o_a,
	output logic signed [FX_W-1:0]          o_i,
	output logic signed [FX_W-1:0]          o_f,
	output logic signed [FX_W-1:0]          o_o,

	// new state and hidden value
	output logic signed [FX_W-1:0]          o_c,
	output logic signed [FX_W-1:0]          o_h
);

	localparam int NUM_IN = NUM_X + 1;

	logic signed [FX_W-1:0] c_reg;
	logic signed [FX_W-1:0] h_reg;
	logic signed [FX_W-1:0] c_prev;
	logic signed [FX_W-1:0] h_prev;
	logic [NUM_IN*FX_W-1:0] k_vec;

	logic signed [FX_W-1:0] mul_ai;
	logic signed [FX_W-1:0] mul_fc;
	logic signed [FX_W-1:0] state;
	logic signed [FX_W-1:0] tanh_state;
	logic signed [FX_W-1:0] h_new;

	////////////////////////////////////////////////////////////////////////////
	// previous state selection
	////////////////////////////////////////////////////////////////////////////

	// i_cont low starts a new sequence from zero
	assign c_prev = i_cont ? c_reg : '0;
	assign h_prev = i_cont ? h_reg : '0;

	// h_prev in the low word, x above it
	assign k_vec = {i_x, h_prev};

	////////////////////////////////////////////////////////////////////////////
	// gates
	////////////////////////////////////////////////////////////////////////////

	gate_neuron #(
		.NUM_IN (NUM_IN),
		.ACT    (ACT_TANH)
	) u_gate_a (
		.clk  (clk),
		.rst  (rst),
		.i_wr (i_wr),
		.i_k  (k_vec),
		.i_w  (i_w_a),
		.i_b  (i_b_a),
		.o_w  (o_w_a),
		.o_b  (o_b_a),
		.o_a  (o_a)
	);

	gate_neuron #(
		.NUM_IN (NUM_IN),
		.ACT    (ACT_SIGMOID)
	) u_gate_i (
		.clk  (clk),
		.rst  (rst),
		.i_wr (i_wr),
		.i_k  (k_vec),
		.i_w  (i_w_i),
		.i_b  (i_b_i),
		.o_w  (o_w_i),
		.o_b  (o_b_i),
		.o_a  (o_i)
	);

	gate_neuron #(
		.NUM_IN (NUM_IN),
		.ACT    (ACT_SIGMOID)
	) u_gate_f (
		.clk  (clk),
		.rst  (rst),
		.i_wr (i_wr),
		.i_k  (k_vec),
		.i_w  (i_w_f),
		.i_b  (i_b_f),
		.o_w  (o_w_f),
		.o_b  (o_b_f),
		.o_a  (o_f)
	);

	gate_neuron #(
		.NUM_IN (NUM_IN),
		.ACT    (ACT_SIGMOID)
	) u_gate_o (
		.clk  (clk),
		.rst  (rst),
		.i_wr (i_wr),
		.i_k  (k_vec),
		.i_w  (i_w_o),
		.i_b  (i_b_o),
		.o_w  (o_w_o),
		.o_b  (o_b_o),
		.o_a  (o_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// state arithmetic
	////////////////////////////////////////////////////////////////////////////

	// state = a*i + f*c_prev
	assign mul_ai = fx_mul(o_a, o_i);
	assign mul_fc = fx_mul(o_f, c_prev);
	assign state  = mul_ai + mul_fc;

	pwl_act #(
		.ACT (ACT_TANH)
	) u_state_tanh (
		.i_x (state),
		.o_y (tanh_state)
	);

	// h = tanh(state) * o
	assign h_new = fx_mul(tanh_state, o_o);

	assign o_c = state;
	assign o_h = h_new;

	// state advances only on a step
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			c_reg <= '0;
			h_reg <= '0;
		end
		else if (i_step)
		begin
			c_reg <= state;
			h_reg <= h_new;
		end
	end

endmodule

// File: verification/lstm_ref.svh
`ifndef LSTM_REF_SVH
`define LSTM_REF_SVH

// 1.0 and 0.5 in Q8.24
localparam logic signed [31:0] REF_ONE  = 32'sh0100_0000;
localparam logic signed [31:0] REF_HALF = 32'sh0080_0000;

// floored Q8.24 product, wraps to 32 bits
function automatic logic signed [31:0] ref_mul
(
	input logic signed [31:0] a,
	input logic signed [31:0] b
);
	longint p;
	p = longint'(a) * longint'(b);
	return 32'(p >>> 24);
endfunction

// x/4 + 1/2 clamped to [0, 1]
function automatic logic signed [31:0] ref_sigmoid(input logic signed [31:0] x);
	logic signed [31:0] y;
	y = (x >>> 2) + REF_HALF;
	if (y < 0)
		return 0;
	if (y > REF_ONE)
		return REF_ONE;
	return y;
endfunction

// x clamped to [-1, 1]
function automatic logic signed [31:0] ref_tanh(input logic signed [31:0] x);
	if (x > REF_ONE)
		return REF_ONE;
	if (x < -REF_ONE)
		return -REF_ONE;
	return x;
endfunction

// bias plus weighted inputs, then the gate's activation
function automatic logic signed [31:0] ref_neuron
(
	input logic [N_IN*32-1:0] w,
	input logic signed [31:0] b,
	input logic [N_IN*32-1:0] k,
	input bit                 use_tanh
);
	logic signed [31:0] acc;
	acc = b;
	for (int n = 0; n < N_IN; n++)
		acc = acc + ref_mul(w[n*32 +: 32], k[n*32 +: 32]);
	return use_tanh ? ref_tanh(acc) : ref_sigmoid(acc);
endfunction

// one cell evaluation from an already selected previous state
function automatic void ref_step
(
	input  logic [NUM_X*32-1:0] x,
	input  logic signed [31:0]  c_in,
	input  logic signed [31:0]  h_in,
	input  logic [N_IN*32-1:0]  w_a, w_i, w_f, w_o,
	input  logic signed [31:0]  b_a, b_i, b_f, b_o,
	output logic signed [31:0]  y_a, y_i, y_f, y_o, y_c, y_h
);
	logic [N_IN*32-1:0] k;
	k = {x, h_in};
	y_a = ref_neuron(w_a, b_a, k, 1'b1);
	y_i = ref_neuron(w_i, b_i, k, 1'b0);
	y_f = ref_neuron(w_f, b_f, k, 1'b0);
	y_o = ref_neuron(w_o, b_o, k, 1'b0);
	y_c = ref_mul(y_a, y_i) + ref_mul(y_f, c_in);
	y_h = ref_mul(ref_tanh(y_c), y_o);
endfunction

`endif

// File: verification/tb_lstm_cell.sv
`timescale 1ns/1ps

module tb_lstm_cell;

	localparam int NUM_X      = 4;
	localparam int N_IN       = NUM_X + 1;
	localparam int MAX_CYCLES = 3000;

	`include "lstm_ref.svh"

	logic clk;
	logic rst;
	logic i_wr;
	logic i_step;
	logic i_cont;
	logic [NUM_X*32-1:0] i_x;
	logic [N_IN*32-1:0] i_w_a, i_w_i, i_w_f, i_w_o;
	logic signed [31:0] i_b_a, i_b_i, i_b_f, i_b_o;
	logic [N_IN*32-1:0] o_w_a, o_w_i, o_w_f, o_w_o;
	logic signed [31:0] o_b_a, o_b_i, o_b_f, o_b_o;
	logic signed [31:0] o_a, o_i, o_f, o_o, o_c, o_h;

	// model copies of weights and state
	logic [N_IN*32-1:0] m_w_a, m_w_i, m_w_f, m_w_o;
	logic signed [31:0] m_b_a, m_b_i, m_b_f, m_b_o;
	logic signed [31:0] m_c, m_h;

	int checks = 0;
	int mismatches = 0;
	int failures = 0;

	lstm_cell #(
		.NUM_X (NUM_X)
	) u_lstm_cell (
		.clk    (clk),    .rst    (rst),
		.i_wr   (i_wr),   .i_step (i_step), .i_cont (i_cont), .i_x (i_x),
		.i_w_a  (i_w_a),  .i_w_i  (i_w_i),  .i_w_f  (i_w_f),  .i_w_o (i_w_o),
		.i_b_a  (i_b_a),  .i_b_i  (i_b_i),  .i_b_f  (i_b_f),  .i_b_o (i_b_o),
		.o_w_a  (o_w_a),  .o_w_i  (o_w_i),  .o_w_f  (o_w_f),  .o_w_o (o_w_o),
		.o_b_a  (o_b_a),  .o_b_i  (o_b_i),  .o_b_f  (o_b_f),  .o_b_o (o_b_o),
		.o_a    (o_a),    .o_i    (o_i),    .o_f    (o_f),    .o_o   (o_o),
		.o_c    (o_c),    .o_h    (o_h)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin : watchdog
		for (int n = 0; n < MAX_CYCLES; n++)
			@(posedge clk);
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks and random values
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			mismatches++;
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bus
	(
		input string              name,
		input logic [N_IN*32-1:0] got,
		input logic [N_IN*32-1:0] exp
	);
		checks++;
		assert (got === exp)
		else
		begin
			mismatches++;
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// uniform in [-span, span]
	function automatic int rand_span(input int span);
		int r;
		r = int'($urandom % (2 * span + 1));
		return r - span;
	endfunction

	function automatic logic [N_IN*32-1:0] random_weights();
		logic [N_IN*32-1:0] w;
		for (int n = 0; n < N_IN; n++)
			w[n*32 +: 32] = rand_span(1 << 23);
		return w;
	endfunction

	function automatic logic [NUM_X*32-1:0] random_inputs();
		logic [NUM_X*32-1:0] x;
		for (int n = 0; n < NUM_X; n++)
			x[n*32 +: 32] = rand_span(1 << 24);
		return x;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare process running before the DUT registers update
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin : compare
		logic signed [31:0] e_a, e_i, e_f, e_o, e_c, e_h;
		if (rst)
		begin
			{m_w_a, m_w_i, m_w_f, m_w_o} = '0;
			{m_b_a, m_b_i, m_b_f, m_b_o} = '0;
			m_c = '0;
			m_h = '0;
		end
		else
		begin
			ref_step(i_x, i_cont ? m_c : 32'sd0, i_cont ? m_h : 32'sd0,
				m_w_a, m_w_i, m_w_f, m_w_o, m_b_a, m_b_i, m_b_f, m_b_o,
				e_a, e_i, e_f, e_o, e_c, e_h);
			check_word("o_a", o_a, e_a);
			check_word("o_i", o_i, e_i);
			check_word("o_f", o_f, e_f);
			check_word("o_o", o_o, e_o);
			check_word("o_c", o_c, e_c);
			check_word("o_h", o_h, e_h);
			check_bus("o_w_a", o_w_a, m_w_a);
			check_bus("o_w_i", o_w_i, m_w_i);
			check_bus("o_w_f", o_w_f, m_w_f);
			check_bus("o_w_o", o_w_o, m_w_o);
			check_word("o_b_a", o_b_a, m_b_a);
			check_word("o_b_i", o_b_i, m_b_i);
			check_word("o_b_f", o_b_f, m_b_f);
			check_word("o_b_o", o_b_o, m_b_o);
			if (i_wr)
			begin
				{m_w_a, m_w_i, m_w_f, m_w_o} = {i_w_a, i_w_i, i_w_f, i_w_o};
				{m_b_a, m_b_i, m_b_f, m_b_o} = {i_b_a, i_b_i, i_b_f, i_b_o};
			end
			if (i_step)
			begin
				m_c = e_c;
				m_h = e_h;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_reset_clear();
		int n;
		n = 0;
		while (o_i !== REF_HALF && n < 10)
		begin
			@(negedge clk);
			n++;
		end
		assert (o_i === REF_HALF)
		else
		begin
			failures++;
			$display("gate outputs did not settle after reset within 10 cycles");
		end
	endtask

	// random weights, and the same bias on every gate when fixed_bias is set
	task automatic load_weights(input bit fixed_bias, input logic signed [31:0] bias);
		@(negedge clk);
		i_w_a = random_weights();
		i_w_i = random_weights();
		i_w_f = random_weights();
		i_w_o = random_weights();
		i_b_a = fixed_bias ? bias : rand_span(1 << 23);
		i_b_i = fixed_bias ? bias : rand_span(1 << 23);
		i_b_f = fixed_bias ? bias : rand_span(1 << 23);
		i_b_o = fixed_bias ? bias : rand_span(1 << 23);
		i_wr = 1'b1;
		@(negedge clk);
		i_wr = 1'b0;
		check_bus("o_w_a", o_w_a, i_w_a);
		check_bus("o_w_i", o_w_i, i_w_i);
		check_bus("o_w_f", o_w_f, i_w_f);
		check_bus("o_w_o", o_w_o, i_w_o);
		check_word("o_b_a", o_b_a, i_b_a);
		check_word("o_b_i", o_b_i, i_b_i);
		check_word("o_b_f", o_b_f, i_b_f);
		check_word("o_b_o", o_b_o, i_b_o);
	endtask

	task automatic step_once(input bit cont);
		@(negedge clk);
		i_x = random_inputs();
		i_cont = cont;
		i_step = 1'b1;
		@(negedge clk);
		i_step = 1'b0;
	endtask

	// x wanders with no step, then returns, and c and h come back unchanged
	task automatic check_hold();
		logic [NUM_X*32-1:0] x0;
		logic signed [31:0] e_a, e_i, e_f, e_o, e_c, e_h;
		x0 = random_inputs();
		@(negedge clk);
		i_cont = 1'b1;
		i_x = x0;
		@(negedge clk);
		// expected from the model state held before x wanders
		ref_step(x0, m_c, m_h,
			m_w_a, m_w_i, m_w_f, m_w_o, m_b_a, m_b_i, m_b_f, m_b_o,
			e_a, e_i, e_f, e_o, e_c, e_h);
		for (int n = 0; n < 6; n++)
		begin
			i_x = random_inputs();
			@(negedge clk);
		end
		i_x = x0;
		@(negedge clk);
		check_word("o_c", o_c, e_c);
		check_word("o_h", o_h, e_h);
	endtask

	// biases far outside the linear range
	task automatic check_clamp
	(
		input logic signed [31:0] bias,
		input logic signed [31:0] exp_a,
		input logic signed [31:0] exp_gate,
		input logic signed [31:0] exp_ch
	);
		load_weights(1'b1, bias);
		step_once(1'b0);
		check_word("o_a", o_a, exp_a);
		check_word("o_i", o_i, exp_gate);
		check_word("o_f", o_f, exp_gate);
		check_word("o_o", o_o, exp_gate);
		check_word("o_c", o_c, exp_ch);
		check_word("o_h", o_h, exp_ch);
		for (int n = 0; n < 3; n++)
			step_once(1'b1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : stimulus
		void'($urandom(32'hb881));
		rst = 1'b1;
		{i_wr, i_step, i_cont} = '0;
		i_x = '0;
		{i_w_a, i_w_i, i_w_f, i_w_o} = '0;
		{i_b_a, i_b_i, i_b_f, i_b_o} = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		wait_reset_clear();

		// reset values
		check_word("o_a", o_a, 0);
		check_word("o_i", o_i, REF_HALF);
		check_word("o_f", o_f, REF_HALF);
		check_word("o_o", o_o, REF_HALF);
		check_word("o_c", o_c, 0);
		check_word("o_h", o_h, 0);
		check_bus("o_w_a", o_w_a, '0);
		check_bus("o_w_o", o_w_o, '0);
		check_word("o_b_f", o_b_f, 0);

		load_weights(1'b0, 0);

		// history, then a restart from zero
		for (int n = 0; n < 5; n++)
			step_once(1'b1);
		step_once(1'b0);

		// long run with random restarts
		for (int n = 0; n < 200; n++)
		begin
			if (n % 50 == 49)
				load_weights(1'b0, 0);
			step_once(($urandom % 16) != 0);
		end
		step_once(1'b1);
		check_hold();

		check_clamp(32'sh0600_0000, REF_ONE, REF_ONE, REF_ONE);
		check_clamp(-32'sh0600_0000, -REF_ONE, 0, 0);

		repeat (2) @(negedge clk);
		$display("checks: %0d, mismatches: %0d, other failures: %0d",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: tb.f
+incdir+verification
source/lstm_pkg.sv
source/pwl_act.sv
source/gate_neuron.sv
source/lstm_cell.sv
verification/tb_lstm_cell.sv

// File: Bender.yml
package:
  name: lstm_cell

sources:
  - source/lstm_pkg.sv
  - source/pwl_act.sv
  - source/gate_neuron.sv
  - source/lstm_cell.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_lstm_cell.sv
